//--- crosshair_checker.sv
// Testbench checker for the crosshair overlay.
// Keeps its own active-pixel counts and a two-enable history of expected output.
// Assumes the raster starts with all counts at zero after reset.

`timescale 1ns/10ps

module crosshair_checker #(
    parameter int colorw  = 4,
    parameter int arm_len = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pxl_cen,
    input  logic                        draw_en,
    input  logic [1:0]                  cross_disable,
    input  crosshair_pkg::video_sync_t  pre_sync,
    input  crosshair_pkg::gun_pos_t     gun_1p,
    input  crosshair_pkg::gun_pos_t     gun_2p,
    input  logic [3*colorw-1:0]         rgb_in,
    input  logic [3*colorw-1:0]         rgb_out,
    input  crosshair_pkg::video_sync_t  sync_out,
    input  int                          test_id,
    output int                          tests_done,
    output int                          check_count,
    output int                          error_count
);

    localparam int rgbw = 3 * colorw;

    // own position of the pixel on rgb_in.
    int                         ref_h;
    int                         ref_v;
    logic                       prev_lhbl;
    // expected results, index 1 is two enables old.
    logic [rgbw-1:0]            hist_rgb [0:1];
    crosshair_pkg::video_sync_t hist_sync [0:1];
    int                         test_errors;
    int                         test_checks;
    int                         last_id;

    function automatic string test_name(input int id);
        case (id)
            1: test_name = "reset_state";
            2: test_name = "pass_through";
            3: test_name = "single_cross";
            4: test_name = "edge_overlap";
            5: test_name = "disable_ctrl";
            6: test_name = "blank_random";
            default: test_name = "unknown";
        endcase
    endfunction

    // full channel of ones for each set selector bit, red on top.
    function automatic logic [rgbw-1:0] channel_fill(input logic [2:0] sel);
        logic [rgbw-1:0] r;
        r = '0;
        for (int c = 0; c < 3; c++) begin
            if (sel[c]) begin
                r[c*colorw +: colorw] = {colorw{1'b1}};
            end
        end
        return r;
    endfunction

    // returns {arm, centre} for one gun.
    function automatic logic [1:0] cross_at(input int h, input int v,
                                            input crosshair_pkg::gun_pos_t g);
        int  ax;
        int  ay;
        logic c;
        ax = (h > int'(g.x)) ? h - int'(g.x) : int'(g.x) - h;
        ay = (v > int'(g.y)) ? v - int'(g.y) : int'(g.y) - v;
        c  = (ax == 0) && (ay == 0);
        return {!c && (((ax == 0) && (ay <= arm_len)) || ((ay == 0) && (ax <= arm_len))), c};
    endfunction

    // reference model of one output pixel.
    function automatic logic [rgbw-1:0] expected_rgb(
        input int h, input int v, input logic de, input logic [1:0] dis,
        input crosshair_pkg::gun_pos_t g1, input crosshair_pkg::gun_pos_t g2,
        input logic [rgbw-1:0] rgb, input crosshair_pkg::video_sync_t s);
        logic [1:0] c1;
        logic [1:0] c2;
        c1 = dis[0] ? 2'b00 : cross_at(h, v, g1);
        c2 = dis[1] ? 2'b00 : cross_at(h, v, g2);
        if (!s.lhbl || !s.lvbl) return '0;
        if (!de) return rgb;
        if (c1[0] || c2[0]) return channel_fill(crosshair_pkg::cross_white_centre);
        if (c1[1]) return channel_fill(crosshair_pkg::cross_red_1p);
        if (c2[1]) return channel_fill(crosshair_pkg::cross_blue_2p);
        return rgb;
    endfunction

    task automatic note_error();
        test_errors++;
        error_count++;
    endtask

    initial begin
        tests_done  = 0;
        check_count = 0;
        error_count = 0;
        test_errors = 0;
        test_checks = 0;
        last_id     = 0;
    end

    always @(posedge clk) begin
        // one summary line as each test finishes.
        if (test_id != last_id) begin
            if (last_id != 0) begin
                $display("test %s: %0d checks, %0d errors, %s", test_name(last_id),
                         test_checks, test_errors, (test_errors == 0) ? "ok" : "bad");
                tests_done++;
            end
            last_id     = test_id;
            test_errors = 0;
            test_checks = 0;
        end
        if (!rst_n) begin
            // outputs held at zero in reset.
            test_checks++;
            check_count++;
            if (rgb_out != '0 || sync_out != '0) begin
                $display("FAILED %s expected %h/%h actual %h/%h", test_name(test_id),
                         {rgbw{1'b0}}, 4'h0, rgb_out, sync_out);
                note_error();
            end
            ref_h     = 0;
            ref_v     = 0;
            prev_lhbl = 1'b0;
            hist_rgb[0]  = '0;
            hist_rgb[1]  = '0;
            hist_sync[0] = '0;
            hist_sync[1] = '0;
        end else if (pxl_cen) begin
            test_checks++;
            check_count++;
            if (rgb_out != hist_rgb[1] || sync_out != hist_sync[1]) begin
                $display("FAILED %s expected %h/%h actual %h/%h", test_name(test_id),
                         hist_rgb[1], hist_sync[1], rgb_out, sync_out);
                note_error();
            end
            if ((!sync_out.lhbl || !sync_out.lvbl) && rgb_out != '0) begin
                $display("colour is not black while the output is blanked");
                note_error();
            end
            hist_rgb[1]  = hist_rgb[0];
            hist_sync[1] = hist_sync[0];
            hist_rgb[0]  = expected_rgb(ref_h, ref_v, draw_en, cross_disable,
                                        gun_1p, gun_2p, rgb_in, pre_sync);
            hist_sync[0] = pre_sync;
            // advance own counts past this pixel.
            if (!pre_sync.lvbl) begin
                ref_v = 0;
            end else if (prev_lhbl && !pre_sync.lhbl) begin
                ref_v++;
            end
            ref_h     = pre_sync.lhbl ? ref_h + 1 : 0;
            prev_lhbl = pre_sync.lhbl;
        end
    end

endmodule

//--- crosshair_draw.sv
// Plus-shaped crosshair detector for one gun.
// Arms reach arm_len pixels from the centre and clip at the screen edge.
// Result is registered on pxl_cen, one enable after the counts.

`timescale 1ns/10ps

module crosshair_draw #(
    parameter int arm_len = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            pxl_cen,
    input  logic [crosshair_pkg::pos_w-1:0] hcnt,
    input  logic [crosshair_pkg::pos_w-1:0] vcnt,
    input  crosshair_pkg::gun_pos_t         pos,
    output crosshair_pkg::cross_hit_t       hit
);

    localparam int pos_w = crosshair_pkg::pos_w;
    // arm length in coordinate width for the compares.
    localparam logic [pos_w-1:0] arm_lim = pos_w'(arm_len);

    // absolute distance from the aim point.
    logic [pos_w-1:0] dx;
    logic [pos_w-1:0] dy;
    logic             on_centre;
    logic             on_arm;

    always_comb begin
        // magnitude by compare, so no modular wrap at the edges.
        if (hcnt >= pos.x) begin
            dx = hcnt - pos.x;
        end else begin
            dx = pos.x - hcnt;
        end
        if (vcnt >= pos.y) begin
            dy = vcnt - pos.y;
        end else begin
            dy = pos.y - vcnt;
        end
        on_centre = (dx == '0) && (dy == '0);
        // vertical arm, then horizontal arm.
        on_arm = !on_centre &&
                 (((dx == '0) && (dy <= arm_lim)) ||
                  ((dy == '0) && (dx <= arm_lim)));
    end

    // stage 1 register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit <= '0;
        end else if (pxl_cen) begin
            hit.arm    <= on_arm;
            hit.centre <= on_centre;
        end
    end

    // centre pixel is never also painted as arm.
    hit_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(hit.arm && hit.centre)
    ) else $error("crosshair arm and centre set together");

endmodule

//--- crosshair_overlay.f
crosshair_pkg.sv
video_counter.sv
crosshair_draw.sv
video_mixer.sv
crosshair_overlay.sv
crosshair_checker.sv
tb_crosshair_overlay.sv

//--- crosshair_overlay.sv
// Light-gun crosshair overlay between a core's video and the video output.
// Draws one plus per gun at its reported active-area position.
// Colour and sync leave exactly two pixel enables after they arrive.
// No screen flip; gun positions are plain levels sampled on pxl_cen.

`timescale 1ns/10ps

module crosshair_overlay #(
    parameter int colorw  = 4,
    parameter int arm_len = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pxl_cen,
    input  logic                        draw_en,
    input  logic [1:0]                  cross_disable,
    input  crosshair_pkg::video_sync_t  pre_sync,
    input  crosshair_pkg::gun_pos_t     gun_1p,
    input  crosshair_pkg::gun_pos_t     gun_2p,
    input  logic [3*colorw-1:0]         rgb_in,
    output logic [3*colorw-1:0]         rgb_out,
    output crosshair_pkg::video_sync_t  sync_out
);

    // active-pixel position of the pixel on rgb_in.
    logic [crosshair_pkg::pos_w-1:0] hcnt;
    logic [crosshair_pkg::pos_w-1:0] vcnt;
    // stage 1 detector results.
    crosshair_pkg::cross_hit_t       hit_1p;
    crosshair_pkg::cross_hit_t       hit_2p;

    video_counter u_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .lhbl    (pre_sync.lhbl),
        .lvbl    (pre_sync.lvbl),
        .hcnt    (hcnt),
        .vcnt    (vcnt)
    );

    crosshair_draw #(.arm_len(arm_len)) u_draw_1p (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .hcnt    (hcnt),
        .vcnt    (vcnt),
        .pos     (gun_1p),
        .hit     (hit_1p)
    );

    crosshair_draw #(.arm_len(arm_len)) u_draw_2p (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .hcnt    (hcnt),
        .vcnt    (vcnt),
        .pos     (gun_2p),
        .hit     (hit_2p)
    );

    // gun 1 wins over gun 2 where the arms overlap.
    video_mixer #(.colorw(colorw)) u_mixer (
        .clk           (clk),
        .rst_n         (rst_n),
        .pxl_cen       (pxl_cen),
        .draw_en       (draw_en),
        .cross_disable (cross_disable),
        .hit_1p        (hit_1p),
        .hit_2p        (hit_2p),
        .rgb_in        (rgb_in),
        .sync_in       (pre_sync),
        .rgb_out       (rgb_out),
        .sync_out      (sync_out)
    );

endmodule

//--- crosshair_pkg.sv
// Shared types and constants for the light-gun crosshair overlay.
// Screen coordinates are limited to 9 bits, so rasters up to 512 wide.
// Crosshair colours are 3-bit selectors, one bit per channel, in r,g,b order.

package crosshair_pkg;

    // width of one screen coordinate.
    localparam int pos_w = 9;

    // sync and blanking levels of one pixel.
    // lhbl and lvbl are high in the active area.
    typedef struct packed {
        logic hs;
        logic vs;
        logic lhbl;
        logic lvbl;
    } video_sync_t;

    // gun aim point in active-pixel coordinates.
    typedef struct packed {
        logic [pos_w-1:0] x;
        logic [pos_w-1:0] y;
    } gun_pos_t;

    // result of one crosshair detector for the current pixel.
    // at most one of the two bits is set.
    typedef struct packed {
        logic arm;
        logic centre;
    } cross_hit_t;

    // colour selectors, bit 2 red, bit 1 green, bit 0 blue.
    // each set bit becomes a full channel of ones in the mixer.
    localparam logic [2:0] cross_red_1p       = 3'b100;
    localparam logic [2:0] cross_blue_2p      = 3'b001;
    localparam logic [2:0] cross_white_centre = 3'b111;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the crosshair overlay testbench with Verilator.
# Run from the project root. Exit status is 0 only when the log shows a pass.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f crosshair_overlay.f \
    --top-module tb_crosshair_overlay \
    -o sim_crosshair
if [ $? -ne 0 ]; then
    echo "build with verilator did not succeed"
    exit 1
fi

./obj_dir/sim_crosshair > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" "$LOG"; then
    exit 0
fi
exit 1

//--- tb_crosshair_overlay.sv
// Testbench top for the crosshair overlay.
// Raster is 40+8 pixels by 30+4 lines with pxl_cen on every second clock.
// Inputs change 10 ns after the rising edge.

`timescale 1ns/10ps

module tb_crosshair_overlay;

    localparam int colorw  = 4;
    localparam int arm_len = 4;
    localparam int rgbw    = 3 * colorw;
    localparam int n_tests = 6;

    logic                       clk;
    logic                       rst_n;
    logic                       pxl_cen;
    logic                       draw_en;
    logic [1:0]                 cross_disable;
    crosshair_pkg::video_sync_t pre_sync;
    crosshair_pkg::gun_pos_t    gun_1p;
    crosshair_pkg::gun_pos_t    gun_2p;
    logic [rgbw-1:0]            rgb_in;
    logic [rgbw-1:0]            rgb_out;
    crosshair_pkg::video_sync_t sync_out;
    int                         test_id;
    int                         tests_done;
    int                         check_count;
    int                         error_count;
    integer                     seed;
    logic [31:0]                rnd;
    int                         n;

    crosshair_overlay #(.colorw(colorw), .arm_len(arm_len)) dut (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .draw_en(draw_en),
        .cross_disable(cross_disable), .pre_sync(pre_sync), .gun_1p(gun_1p),
        .gun_2p(gun_2p), .rgb_in(rgb_in), .rgb_out(rgb_out), .sync_out(sync_out)
    );

    crosshair_checker #(.colorw(colorw), .arm_len(arm_len)) u_check (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .draw_en(draw_en),
        .cross_disable(cross_disable), .pre_sync(pre_sync), .gun_1p(gun_1p),
        .gun_2p(gun_2p), .rgb_in(rgb_in), .rgb_out(rgb_out), .sync_out(sync_out),
        .test_id(test_id), .tests_done(tests_done), .check_count(check_count),
        .error_count(error_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one pixel as an enable cycle then an idle cycle.
    task automatic drive_pixel(input int h, input int v);
        @(posedge clk);
        #10;
        rnd           = $random(seed);
        pxl_cen       = 1'b1;
        rgb_in        = rnd[rgbw-1:0];
        pre_sync.lhbl = (h < 40);
        pre_sync.lvbl = (v < 30);
        pre_sync.hs   = (h >= 42) && (h < 46);
        pre_sync.vs   = (v >= 31) && (v < 33);
        @(posedge clk);
        #10;
        pxl_cen = 1'b0;
    endtask

    // full frame with draw_en flipped at the start of toggle_line.
    task automatic run_frame(input int toggle_line);
        for (int v = 0; v < 34; v++) begin
            for (int h = 0; h < 48; h++) begin
                if (v == toggle_line && h == 0) begin
                    draw_en = !draw_en;
                end
                drive_pixel(h, v);
            end
        end
    endtask

    task automatic place_guns(input int x1, input int y1, input int x2, input int y2);
        gun_1p.x = 9'(x1);
        gun_1p.y = 9'(y1);
        gun_2p.x = 9'(x2);
        gun_2p.y = 9'(y2);
    endtask

    // global limit on the run.
    initial begin
        for (int w = 0; w < 60000; w++) begin
            @(posedge clk);
        end
        $display("simulation did not finish within the cycle limit");
        $display("Verification failed");
        $finish;
    end

    initial begin
        seed          = 41673;
        rst_n         = 1'b0;
        pxl_cen       = 1'b0;
        draw_en       = 1'b0;
        cross_disable = 2'b11;
        pre_sync      = '0;
        gun_1p        = '0;
        gun_2p        = '0;
        rgb_in        = '0;
        test_id       = 1;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
        end
        #10;
        rst_n = 1'b1;
        drive_pixel(47, 33);
        test_id = 2;
        place_guns(20, 15, 5, 5);
        cross_disable = 2'b00;
        run_frame(-1);
        test_id = 3;
        draw_en = 1'b1;
        cross_disable = 2'b10;
        run_frame(-1);
        test_id = 4;
        place_guns(0, 0, 2, 0);
        cross_disable = 2'b00;
        run_frame(-1);
        test_id = 5;
        place_guns(10, 10, 12, 12);
        // draw_en flips inside both crosshairs, so each half shows both guns.
        for (int f = 0; f < 4; f++) begin
            cross_disable = 2'(f);
            run_frame(12);
        end
        test_id = 6;
        draw_en = 1'b1;
        cross_disable = 2'b00;
        for (int f = 0; f < 3; f++) begin
            rnd = $random(seed);
            place_guns(int'(rnd[7:0]) % 40, int'(rnd[15:8]) % 30,
                       int'(rnd[23:16]) % 40, int'(rnd[31:24]) % 30);
            run_frame(-1);
        end
        // flush the two-stage pipeline with blank pixels.
        for (int i = 0; i < 4; i++) begin
            drive_pixel(47, 33);
        end
        test_id = 0;
        n = 0;
        while (tests_done < n_tests && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (tests_done < n_tests) begin
            $display("checker did not report every test in time");
        end
        $display("tests %0d, checks %0d, errors %0d", tests_done, check_count, error_count);
        if (error_count == 0 && tests_done == n_tests) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- video_counter.sv
// Active-area position counter, driven by the pre-blanking levels.
// Counts only advance on pxl_cen and describe the pixel present on that enable.
// Assumes lvbl only changes while lhbl is low.

`timescale 1ns/10ps

module video_counter (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            pxl_cen,
    input  logic                            lhbl,
    input  logic                            lvbl,
    output logic [crosshair_pkg::pos_w-1:0] hcnt,
    output logic [crosshair_pkg::pos_w-1:0] vcnt
);

    // blanking levels seen on the previous pixel enable.
    logic lhbl_l;
    logic lvbl_l;
    // falling edges of the active levels.
    logic line_end;
    logic frame_end;

    assign line_end  = lhbl_l && !lhbl;
    assign frame_end = lvbl_l && !lvbl;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_l <= 1'b0;
            lvbl_l <= 1'b0;
            hcnt   <= '0;
            vcnt   <= '0;
        end else if (pxl_cen) begin
            lhbl_l <= lhbl;
            lvbl_l <= lvbl;
            // active pixel has now passed.
            if (lhbl) begin
                hcnt <= hcnt + 1'b1;
            end else if (line_end) begin
                hcnt <= '0;
            end
            // lvbl_l holds the level of the last active pixel.
            // so blanking lines never advance the line count.
            if (frame_end) begin
                vcnt <= '0;
            end else if (line_end && lvbl_l) begin
                vcnt <= vcnt + 1'b1;
            end
        end
    end

    // line must end before the horizontal count runs out.
    hcnt_no_wrap: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pxl_cen && lhbl) |-> (hcnt != '1)
    ) else $error("hcnt wrapped inside an active line");

endmodule

//--- video_mixer.sv
// Colour priority and blanking for the crosshair overlay.
// Stage 1 holds the pixel and its controls next to the registered hits.
// Stage 2 registers the final colour and sync, so output latency is two enables.
// rgb is packed red, green, blue with colorw bits per channel.

`timescale 1ns/10ps

module video_mixer #(
    parameter int colorw = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pxl_cen,
    input  logic                        draw_en,
    input  logic [1:0]                  cross_disable,
    input  crosshair_pkg::cross_hit_t   hit_1p,
    input  crosshair_pkg::cross_hit_t   hit_2p,
    input  logic [3*colorw-1:0]         rgb_in,
    input  crosshair_pkg::video_sync_t  sync_in,
    output logic [3*colorw-1:0]         rgb_out,
    output crosshair_pkg::video_sync_t  sync_out
);

    localparam int rgbw = 3 * colorw;

    // stage 1 copies that line up with hit_1p and hit_2p.
    logic [rgbw-1:0]            rgb_d;
    crosshair_pkg::video_sync_t sync_d;
    logic                       draw_en_d;
    logic [1:0]                 disable_d;
    // per-gun enables after the disable bits.
    logic                       show_1p;
    logic                       show_2p;
    logic [rgbw-1:0]            rgb_mix;

    // widen a 3-bit selector to full channels.
    function automatic logic [rgbw-1:0] expand(input logic [2:0] sel);
        expand = {{colorw{sel[2]}}, {colorw{sel[1]}}, {colorw{sel[0]}}};
    endfunction

    // stage 1 pixel colour.
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            rgb_d <= rgb_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_d    <= '0;
            draw_en_d <= 1'b0;
            disable_d <= 2'b11;
        end else if (pxl_cen) begin
            sync_d    <= sync_in;
            draw_en_d <= draw_en;
            disable_d <= cross_disable;
        end
    end

    assign show_1p = !disable_d[0];
    assign show_2p = !disable_d[1];

    always_comb begin
        if (!sync_d.lhbl || !sync_d.lvbl) begin
            rgb_mix = '0;
        end else if (!draw_en_d) begin
            rgb_mix = rgb_d;
        end else if ((show_1p && hit_1p.centre) || (show_2p && hit_2p.centre)) begin
            rgb_mix = expand(crosshair_pkg::cross_white_centre);
        end else if (show_1p && hit_1p.arm) begin
            rgb_mix = expand(crosshair_pkg::cross_red_1p);
        end else if (show_2p && hit_2p.arm) begin
            rgb_mix = expand(crosshair_pkg::cross_blue_2p);
        end else begin
            rgb_mix = rgb_d;
        end
    end

    // stage 2 register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb_out  <= '0;
            sync_out <= '0;
        end else if (pxl_cen) begin
            rgb_out  <= rgb_mix;
            sync_out <= sync_d;
        end
    end

    // no colour leaks into the blanking.
    blank_is_black: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(sync_out.lhbl && sync_out.lvbl) |-> (rgb_out == '0)
    ) else $error("non-zero colour during blanking");

endmodule
